//--- hw/cray_mem_pkg.sv
// Memory front end package with widths, buffer geometry, bus structs and arbiter states
`default_nettype none

package cray_mem_pkg;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////
    typedef logic [63:0] word_t;
    typedef logic [21:0] addr_t;
    typedef logic [15:0] parcel_t;
    // Upper 22 bits are the word address, low 2 bits pick the parcel
    typedef logic [23:0] paddr_t;
    typedef logic [1:0]  ibuf_idx_t;
    typedef logic [3:0]  word_idx_t;
    // Upper 18 bits of a word address, buffers sit on 16-word boundaries
    typedef logic [17:0] tag_t;

    // Buffer geometry
    localparam int IBUF_COUNT       = 4;
    localparam int IBUF_WORDS       = 16;
    localparam int PARCELS_PER_WORD = 4;

    ////////////////////////////////////////////////////////////
    // External memory port
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic  req;
        addr_t addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic  addr_ack;
        logic  ack;
        word_t data;
    } mem_rd_rsp_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
        word_t data;
    } mem_wr_req_t;

    typedef struct packed {
        logic addr_ack;
        logic ack;
    } mem_wr_rsp_t;

    ////////////////////////////////////////////////////////////
    // Memory functional unit port
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t data;
    } mfu_req_t;

    // Read word is zero on a write response
    typedef struct packed {
        logic  wr;
        word_t data;
    } mfu_rsp_t;

    // Arbiter states
    typedef enum logic [2:0] {
        ARB_IDLE,
        ARB_MFU_ADDR,
        ARB_MFU_DATA,
        ARB_FILL_ADDR,
        ARB_FILL_DRAIN
    } arb_state_t;

endpackage

`default_nettype wire

//--- hw/mem_arb_fsm.sv
// Memory arbiter FSM granting the external port to the MFU or to a buffer fill
`timescale 1ns/1ps
`default_nettype none

module mem_arb_fsm (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_fill_req,
    input  wire                       i_mfu_pend,
    input  wire                       i_mfu_wr,
    input  wire                       i_last_addr,
    input  wire                       i_fill_done,
    input  wire cray_mem_pkg::mem_rd_rsp_t i_mem_rd,
    input  wire cray_mem_pkg::mem_wr_rsp_t i_mem_wr,
    output logic                      o_rd_req,
    output logic                      o_wr_req,
    output logic                      o_rd_sel_mfu,
    output logic                      o_fill_start,
    output logic                      o_addr_ack,
    output logic                      o_data_ack,
    output logic                      o_rd_grant_fill,
    output logic                      o_rd_grant_mfu,
    output logic                      o_mfu_done
);

    cray_mem_pkg::arb_state_t state;
    cray_mem_pkg::arb_state_t state_nxt;
    logic                     mfu_addr_ack;
    logic                     mfu_data_ack;
    logic                     in_fill;

    // MFU handshakes come from whichever channel its request uses
    assign mfu_addr_ack = i_mfu_wr ? i_mem_wr.addr_ack : i_mem_rd.addr_ack;
    assign mfu_data_ack = i_mfu_wr ? i_mem_wr.ack : i_mem_rd.ack;

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            cray_mem_pkg::ARB_IDLE: begin
                // MFU goes first, a fill waits its turn
                if (i_mfu_pend) begin
                    state_nxt = cray_mem_pkg::ARB_MFU_ADDR;
                end else if (i_fill_req) begin
                    state_nxt = cray_mem_pkg::ARB_FILL_ADDR;
                end
            end
            cray_mem_pkg::ARB_MFU_ADDR: begin
                if (mfu_addr_ack) begin
                    state_nxt = cray_mem_pkg::ARB_MFU_DATA;
                end
            end
            cray_mem_pkg::ARB_MFU_DATA: begin
                if (mfu_data_ack) begin
                    state_nxt = cray_mem_pkg::ARB_IDLE;
                end
            end
            cray_mem_pkg::ARB_FILL_ADDR: begin
                if (i_mem_rd.addr_ack && i_last_addr) begin
                    state_nxt = cray_mem_pkg::ARB_FILL_DRAIN;
                end
            end
            cray_mem_pkg::ARB_FILL_DRAIN: begin
                // Remaining words still in flight
                if (i_fill_done) begin
                    state_nxt = cray_mem_pkg::ARB_IDLE;
                end
            end
            default: state_nxt = cray_mem_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= cray_mem_pkg::ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs, all decoded from state
    ////////////////////////////////////////////////////////////
    assign in_fill = (state == cray_mem_pkg::ARB_FILL_ADDR) ||
                     (state == cray_mem_pkg::ARB_FILL_DRAIN);

    assign o_rd_req = (state == cray_mem_pkg::ARB_FILL_ADDR) ||
                      ((state == cray_mem_pkg::ARB_MFU_ADDR) && !i_mfu_wr);
    assign o_wr_req     = (state == cray_mem_pkg::ARB_MFU_ADDR) && i_mfu_wr;
    assign o_rd_sel_mfu = state == cray_mem_pkg::ARB_MFU_ADDR;
    assign o_fill_start = (state == cray_mem_pkg::ARB_IDLE) && !i_mfu_pend && i_fill_req;

    // Fill handshakes for the counter
    assign o_addr_ack = (state == cray_mem_pkg::ARB_FILL_ADDR) && i_mem_rd.addr_ack;
    assign o_data_ack = in_fill && i_mem_rd.ack;

    assign o_rd_grant_fill = in_fill;
    assign o_rd_grant_mfu  = (state == cray_mem_pkg::ARB_MFU_DATA) && !i_mfu_wr;
    assign o_mfu_done      = (state == cray_mem_pkg::ARB_MFU_DATA) && mfu_data_ack;

endmodule

`default_nettype wire

//--- hw/ibuf_fill_counter.sv
// Fill counter tracking issued addresses and returned words of one buffer fill
`timescale 1ns/1ps
`default_nettype none

module ibuf_fill_counter (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_fill_start,
    input  wire                     i_addr_ack,
    input  wire                     i_data_ack,
    output cray_mem_pkg::word_idx_t o_addr_idx,
    output cray_mem_pkg::word_idx_t o_data_idx,
    output logic                    o_last_addr,
    output logic                    o_fill_done
);

    // Both counters wrap back to zero after the last word
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_addr_idx <= '0;
            o_data_idx <= '0;
        end else if (i_fill_start) begin
            o_addr_idx <= '0;
            o_data_idx <= '0;
        end else begin
            if (i_addr_ack) begin
                o_addr_idx <= o_addr_idx + 1'b1;
            end
            if (i_data_ack) begin
                o_data_idx <= o_data_idx + 1'b1;
            end
        end
    end

    // Address on the bus is the final one of the block
    assign o_last_addr = o_addr_idx == cray_mem_pkg::word_idx_t'(cray_mem_pkg::IBUF_WORDS - 1);
    assign o_fill_done = i_data_ack &&
                         (o_data_idx == cray_mem_pkg::word_idx_t'(cray_mem_pkg::IBUF_WORDS - 1));

endmodule

`default_nettype wire

//--- hw/ibuf_store.sv
// Instruction buffer set with tag lookup, parcel select and block fill
`timescale 1ns/1ps
`default_nettype none

module ibuf_store (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire cray_mem_pkg::paddr_t i_p_addr,
    input  wire                       i_clear_ibuf,
    input  wire                       i_fill_wr,
    input  wire cray_mem_pkg::word_idx_t i_fill_idx,
    input  wire cray_mem_pkg::word_t  i_fill_data,
    input  wire                       i_fill_done,
    output logic                      o_fill_req,
    output cray_mem_pkg::tag_t        o_fill_tag,
    output cray_mem_pkg::parcel_t     o_nip,
    output cray_mem_pkg::word_t       o_word,
    output logic                      o_nip_vld
);

    // Buffer storage and tags
    cray_mem_pkg::word_t ibuf_mem [cray_mem_pkg::IBUF_COUNT][cray_mem_pkg::IBUF_WORDS];
    cray_mem_pkg::tag_t  buf_tag  [cray_mem_pkg::IBUF_COUNT];
    logic [cray_mem_pkg::IBUF_COUNT-1:0] buf_vld;

    cray_mem_pkg::ibuf_idx_t rr_ptr;
    cray_mem_pkg::ibuf_idx_t fill_buf;

    // Fields of the parcel address
    cray_mem_pkg::tag_t      p_tag;
    cray_mem_pkg::word_idx_t p_widx;
    logic [1:0]              p_sel;

    logic                    hit;
    cray_mem_pkg::ibuf_idx_t hit_buf;
    logic                    miss_start;
    cray_mem_pkg::word_t     cur_word;
    cray_mem_pkg::parcel_t [cray_mem_pkg::PARCELS_PER_WORD-1:0] cur_parcels;

    assign p_tag  = i_p_addr[23:6];
    assign p_widx = i_p_addr[5:2];
    assign p_sel  = i_p_addr[1:0];

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////
    always_comb begin
        hit     = 1'b0;
        hit_buf = '0;
        for (int b = 0; b < cray_mem_pkg::IBUF_COUNT; b++) begin
            if (buf_vld[b] && (buf_tag[b] == p_tag)) begin
                hit     = 1'b1;
                hit_buf = cray_mem_pkg::ibuf_idx_t'(b);
            end
        end
    end

    assign cur_word    = ibuf_mem[hit_buf][p_widx];
    assign cur_parcels = cur_word;

    // Only one fill at a time, a new miss waits for the current one
    assign miss_start = !o_fill_req && !hit;

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            buf_vld    <= '0;
            o_fill_req <= 1'b0;
            rr_ptr     <= '0;
            o_nip_vld  <= 1'b0;
        end else begin
            o_nip_vld <= hit;
            if (i_clear_ibuf) begin
                buf_vld <= '0;
            end
            if (o_fill_req) begin
                // Finishing fill is validated even after a clear
                if (i_fill_done) begin
                    o_fill_req        <= 1'b0;
                    buf_vld[fill_buf] <= 1'b1;
                    rr_ptr            <= fill_buf + 1'b1;
                end
            end else if (miss_start) begin
                o_fill_req      <= 1'b1;
                buf_vld[rr_ptr] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (miss_start) begin
            o_fill_tag <= p_tag;
            fill_buf   <= rr_ptr;
        end
        if (i_fill_wr) begin
            ibuf_mem[fill_buf][i_fill_idx] <= i_fill_data;
        end
        if (i_fill_done) begin
            buf_tag[fill_buf] <= o_fill_tag;
        end
        // Parcel 0 is the top of the word
        o_nip  <= cur_parcels[~p_sel];
        o_word <= cur_word;
    end

endmodule

`default_nettype wire

//--- hw/mfu_port.sv
// MFU port holding one accepted request until memory completes it
`timescale 1ns/1ps
`default_nettype none

module mfu_port (
    input  wire                         clk,
    input  wire                         i_rst_n,
    input  wire                         i_mfu_valid,
    output logic                        o_mfu_ready,
    input  wire cray_mem_pkg::mfu_req_t i_mfu_req,
    input  wire                         i_mfu_done,
    input  wire cray_mem_pkg::word_t    i_rd_data,
    output logic                        o_pend,
    output cray_mem_pkg::mfu_req_t      o_held,
    output logic                        o_mfu_rsp_valid,
    output cray_mem_pkg::mfu_rsp_t      o_mfu_rsp
);

    logic accept;

    // Single entry, so no new request while one is held
    assign o_mfu_ready = !o_pend;
    assign accept      = i_mfu_valid && !o_pend;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pend          <= 1'b0;
            o_mfu_rsp_valid <= 1'b0;
        end else begin
            o_mfu_rsp_valid <= i_mfu_done;
            if (i_mfu_done) begin
                o_pend <= 1'b0;
            end else if (accept) begin
                o_pend <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Request and response payload
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            o_held <= i_mfu_req;
        end
        if (i_mfu_done) begin
            o_mfu_rsp.wr   <= o_held.wr;
            // Writes return no data
            o_mfu_rsp.data <= o_held.wr ? '0 : i_rd_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/cray_mem_front.sv
// Memory front end top connecting instruction buffers, MFU port and arbiter to memory
`timescale 1ns/1ps
`default_nettype none

module cray_mem_front (
    input  wire                            clk,
    input  wire                            i_rst_n,
    // Instruction side
    input  wire cray_mem_pkg::paddr_t      i_p_addr,
    input  wire                            i_clear_ibuf,
    output cray_mem_pkg::parcel_t          o_nip,
    output cray_mem_pkg::word_t            o_word,
    output logic                           o_nip_vld,
    // MFU side
    input  wire                            i_mfu_valid,
    output logic                           o_mfu_ready,
    input  wire cray_mem_pkg::mfu_req_t    i_mfu_req,
    output logic                           o_mfu_rsp_valid,
    output cray_mem_pkg::mfu_rsp_t         o_mfu_rsp,
    // External memory
    output cray_mem_pkg::mem_rd_req_t      o_mem_rd,
    input  wire cray_mem_pkg::mem_rd_rsp_t i_mem_rd,
    output cray_mem_pkg::mem_wr_req_t      o_mem_wr,
    input  wire cray_mem_pkg::mem_wr_rsp_t i_mem_wr
);

    logic                    fill_req;
    cray_mem_pkg::tag_t      fill_tag;
    logic                    fill_start;
    logic                    addr_ack;
    logic                    data_ack;
    logic                    last_addr;
    logic                    fill_done;
    cray_mem_pkg::word_idx_t addr_idx;
    cray_mem_pkg::word_idx_t data_idx;
    logic                    mfu_pend;
    cray_mem_pkg::mfu_req_t  mfu_held;
    logic                    mfu_done;
    logic                    rd_req;
    logic                    wr_req;
    logic                    rd_sel_mfu;
    logic                    rd_grant_fill;
    logic                    rd_grant_mfu;
    cray_mem_pkg::word_t     ibuf_data;
    cray_mem_pkg::word_t     mfu_data;

    ////////////////////////////////////////////////////////////
    // Memory port wiring
    ////////////////////////////////////////////////////////////
    assign o_mem_rd.req  = rd_req;
    assign o_mem_rd.addr = rd_sel_mfu ? mfu_held.addr : {fill_tag, addr_idx};
    assign o_mem_wr.req  = wr_req;
    assign o_mem_wr.addr = mfu_held.addr;
    assign o_mem_wr.data = mfu_held.data;

    // Read data steered to its owner
    assign ibuf_data = rd_grant_fill ? i_mem_rd.data : '0;
    assign mfu_data  = rd_grant_mfu ? i_mem_rd.data : '0;

    ibuf_store ibuf_store_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_p_addr    (i_p_addr),
        .i_clear_ibuf(i_clear_ibuf),
        .i_fill_wr   (data_ack),
        .i_fill_idx  (data_idx),
        .i_fill_data (ibuf_data),
        .i_fill_done (fill_done),
        .o_fill_req  (fill_req),
        .o_fill_tag  (fill_tag),
        .o_nip       (o_nip),
        .o_word      (o_word),
        .o_nip_vld   (o_nip_vld)
    );

    mem_arb_fsm mem_arb_fsm_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_fill_req     (fill_req),
        .i_mfu_pend     (mfu_pend),
        .i_mfu_wr       (mfu_held.wr),
        .i_last_addr    (last_addr),
        .i_fill_done    (fill_done),
        .i_mem_rd       (i_mem_rd),
        .i_mem_wr       (i_mem_wr),
        .o_rd_req       (rd_req),
        .o_wr_req       (wr_req),
        .o_rd_sel_mfu   (rd_sel_mfu),
        .o_fill_start   (fill_start),
        .o_addr_ack     (addr_ack),
        .o_data_ack     (data_ack),
        .o_rd_grant_fill(rd_grant_fill),
        .o_rd_grant_mfu (rd_grant_mfu),
        .o_mfu_done     (mfu_done)
    );

    ibuf_fill_counter ibuf_fill_counter_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_fill_start(fill_start),
        .i_addr_ack  (addr_ack),
        .i_data_ack  (data_ack),
        .o_addr_idx  (addr_idx),
        .o_data_idx  (data_idx),
        .o_last_addr (last_addr),
        .o_fill_done (fill_done)
    );

    mfu_port mfu_port_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_mfu_valid    (i_mfu_valid),
        .o_mfu_ready    (o_mfu_ready),
        .i_mfu_req      (i_mfu_req),
        .i_mfu_done     (mfu_done),
        .i_rd_data      (mfu_data),
        .o_pend         (mfu_pend),
        .o_held         (mfu_held),
        .o_mfu_rsp_valid(o_mfu_rsp_valid),
        .o_mfu_rsp      (o_mfu_rsp)
    );

endmodule

`default_nettype wire

//--- bench/tb_mem_model.sv
// Main memory model with in-order read data and random acknowledge delays
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  wire                            clk,
    input  wire cray_mem_pkg::mem_rd_req_t i_mem_rd,
    output cray_mem_pkg::mem_rd_rsp_t      o_mem_rd,
    input  wire cray_mem_pkg::mem_wr_req_t i_mem_wr,
    output cray_mem_pkg::mem_wr_rsp_t      o_mem_wr
);

    // Sparse storage, only written words are kept
    cray_mem_pkg::word_t       mem [cray_mem_pkg::addr_t];
    cray_mem_pkg::addr_t       rd_queue [$];
    cray_mem_pkg::mem_rd_rsp_t rd_rsp       = '0;
    cray_mem_pkg::mem_wr_rsp_t wr_rsp       = '0;
    integer                    seed         = 32'h60a358ee;
    int                        rd_addr_wait = 0;
    int                        rd_data_wait = 0;
    int                        wr_addr_wait = 0;
    int                        wr_ack_wait  = 0;
    logic                      wr_pending   = 1'b0;

    assign o_mem_rd = rd_rsp;
    assign o_mem_wr = wr_rsp;

    // Zero to three idle cycles
    function automatic int next_delay();
        int r;
        r = $random(seed);
        return r & 3;
    endfunction

    // Unwritten words hold the address, inverted copy on top
    function automatic cray_mem_pkg::word_t read_word(input cray_mem_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {~{10'h000, a}, {10'h000, a}};
    endfunction

    ////////////////////////////////////////////////////////////
    // Both channels step on the falling edge
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        cray_mem_pkg::addr_t a;
        rd_rsp <= '0;
        wr_rsp <= '0;
        // Data for addresses taken at earlier edges, oldest first
        if (rd_queue.size() > 0) begin
            if (rd_data_wait == 0) begin
                a = rd_queue.pop_front();
                rd_rsp.ack   <= 1'b1;
                rd_rsp.data  <= read_word(a);
                rd_data_wait = next_delay();
            end else begin
                rd_data_wait = rd_data_wait - 1;
            end
        end
        // Request is steady until the next rising edge
        if (i_mem_rd.req) begin
            if (rd_addr_wait == 0) begin
                rd_rsp.addr_ack <= 1'b1;
                rd_queue.push_back(i_mem_rd.addr);
                rd_addr_wait = next_delay();
            end else begin
                rd_addr_wait = rd_addr_wait - 1;
            end
        end
        // One write in flight at most
        if (wr_pending) begin
            if (wr_ack_wait == 0) begin
                wr_rsp.ack <= 1'b1;
                wr_pending = 1'b0;
            end else begin
                wr_ack_wait = wr_ack_wait - 1;
            end
        end else if (i_mem_wr.req) begin
            if (wr_addr_wait == 0) begin
                wr_rsp.addr_ack <= 1'b1;
                mem[i_mem_wr.addr] = i_mem_wr.data;
                wr_pending   = 1'b1;
                wr_ack_wait  = next_delay();
                wr_addr_wait = next_delay();
            end else begin
                wr_addr_wait = wr_addr_wait - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_cray_mem_front.sv
// Testbench for the memory front end with directed instruction and MFU tests
`timescale 1ns/1ps
`default_nettype none

module tb_cray_mem_front;

    logic                      clk;
    logic                      rst_n;
    cray_mem_pkg::paddr_t      p_addr;
    logic                      clear_ibuf;
    cray_mem_pkg::parcel_t     nip;
    cray_mem_pkg::word_t       nip_word;
    logic                      nip_vld;
    logic                      mfu_valid;
    logic                      mfu_ready;
    cray_mem_pkg::mfu_req_t    mfu_req;
    logic                      mfu_rsp_valid;
    cray_mem_pkg::mfu_rsp_t    mfu_rsp;
    cray_mem_pkg::mem_rd_req_t mem_rd_req;
    cray_mem_pkg::mem_rd_rsp_t mem_rd_rsp;
    cray_mem_pkg::mem_wr_req_t mem_wr_req;
    cray_mem_pkg::mem_wr_rsp_t mem_wr_rsp;
    int                        wait_limit = 400;
    // MFU word kept away from every instruction block
    cray_mem_pkg::addr_t       mfu_addr   = 22'h2A5C3;
    cray_mem_pkg::word_t       mfu_wdata  = 64'hDEAD_BEEF_0123_4567;

    cray_mem_front cray_mem_front_inst (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_p_addr       (p_addr),
        .i_clear_ibuf   (clear_ibuf),
        .o_nip          (nip),
        .o_word         (nip_word),
        .o_nip_vld      (nip_vld),
        .i_mfu_valid    (mfu_valid),
        .o_mfu_ready    (mfu_ready),
        .i_mfu_req      (mfu_req),
        .o_mfu_rsp_valid(mfu_rsp_valid),
        .o_mfu_rsp      (mfu_rsp),
        .o_mem_rd       (mem_rd_req),
        .i_mem_rd       (mem_rd_rsp),
        .o_mem_wr       (mem_wr_req),
        .i_mem_wr       (mem_wr_rsp)
    );

    tb_mem_model tb_mem_model_inst (
        .clk     (clk),
        .i_mem_rd(mem_rd_req),
        .o_mem_rd(mem_rd_rsp),
        .i_mem_wr(mem_wr_req),
        .o_mem_wr(mem_wr_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Expected values and compares
    ////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic cray_mem_pkg::word_t default_word(input cray_mem_pkg::addr_t a);
        return {~{10'h000, a}, {10'h000, a}};
    endfunction

    function automatic cray_mem_pkg::parcel_t expected_parcel(input cray_mem_pkg::paddr_t pa);
        cray_mem_pkg::word_t w;
        int                  sel;
        w   = default_word(pa[23:2]);
        sel = int'(pa[1:0]);
        // Parcel 0 is the top 16 bits
        return cray_mem_pkg::parcel_t'(w >> (16 * (3 - sel)));
    endfunction

    function automatic cray_mem_pkg::tag_t block_tag(input int k);
        return cray_mem_pkg::tag_t'(18'h01011 * (k + 1));
    endfunction

    task automatic expect_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at time %0t: %s is %b, expected %b",
                                    $time, what, got, exp));
        end
    endtask

    task automatic compare_parcel(input cray_mem_pkg::parcel_t got,
                                  input cray_mem_pkg::parcel_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at time %0t: %s parcel %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic compare_word(input cray_mem_pkg::word_t got,
                                input cray_mem_pkg::word_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at time %0t: %s word %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic compare_mfu_rsp(input cray_mem_pkg::mfu_rsp_t got,
                                   input cray_mem_pkg::mfu_rsp_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at time %0t: %s wr=%b data=%h, expected wr=%b data=%h",
                                    $time, what, got.wr, got.data, exp.wr, exp.data));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus level tasks, all start and end on a falling edge
    ////////////////////////////////////////////////////////////
    task automatic fetch_parcel(input cray_mem_pkg::paddr_t pa, output int low_cycles);
        int n;
        n      = 0;
        p_addr = pa;
        @(negedge clk);
        while (!nip_vld) begin
            n = n + 1;
            if (n > wait_limit) begin
                stop_on_error("Timed out waiting for o_nip_vld after an instruction miss");
            end
            @(negedge clk);
        end
        low_cycles = n;
        compare_parcel(nip, expected_parcel(pa), "fetched");
        compare_word(nip_word, default_word(pa[23:2]), "fetched");
    endtask

    // Every parcel of a resident block, one cycle each
    task automatic check_block_hits(input cray_mem_pkg::tag_t tag);
        cray_mem_pkg::paddr_t pa;
        for (int i = 0; i < cray_mem_pkg::IBUF_WORDS * cray_mem_pkg::PARCELS_PER_WORD; i++) begin
            pa     = {tag, 6'(i)};
            p_addr = pa;
            @(negedge clk);
            expect_flag(nip_vld, 1'b1, "o_nip_vld on a hit");
            compare_parcel(nip, expected_parcel(pa), "hit");
            compare_word(nip_word, default_word(pa[23:2]), "hit");
        end
    endtask

    task automatic mfu_access(input cray_mem_pkg::mfu_req_t req,
                              output cray_mem_pkg::mfu_rsp_t rsp);
        int n;
        mfu_valid = 1'b1;
        mfu_req   = req;
        n         = 0;
        while (!mfu_ready) begin
            n = n + 1;
            if (n > wait_limit) begin
                stop_on_error("Timed out waiting for o_mfu_ready");
            end
            @(negedge clk);
        end
        // Ready is high here, so the next rising edge takes the request
        @(negedge clk);
        mfu_valid = 1'b0;
        mfu_req   = '0;
        n         = 0;
        while (!mfu_rsp_valid) begin
            n = n + 1;
            if (n > wait_limit) begin
                stop_on_error("Timed out waiting for the MFU response");
            end
            @(negedge clk);
        end
        rsp = mfu_rsp;
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic after_reset();
        expect_flag(nip_vld, 1'b0, "o_nip_vld after reset");
        expect_flag(mfu_rsp_valid, 1'b0, "o_mfu_rsp_valid after reset");
        expect_flag(mfu_ready, 1'b1, "o_mfu_ready after reset");
        expect_flag(mem_rd_req.req, 1'b0, "read request after reset");
        expect_flag(mem_wr_req.req, 1'b0, "write request after reset");
    endtask

    task automatic miss_then_hits();
        int low;
        fetch_parcel({22'h12345, 2'd2}, low);
        expect_flag(low > 1, 1'b1, "o_nip_vld low during a miss");
        check_block_hits(18'h01234);
    endtask

    task automatic mfu_write_then_read();
        cray_mem_pkg::mfu_req_t req;
        cray_mem_pkg::mfu_rsp_t rsp;
        cray_mem_pkg::mfu_rsp_t exp;
        req.wr   = 1'b1;
        req.addr = mfu_addr;
        req.data = mfu_wdata;
        mfu_access(req, rsp);
        exp.wr   = 1'b1;
        exp.data = '0;
        compare_mfu_rsp(rsp, exp, "MFU write");
        req.wr   = 1'b0;
        req.data = '0;
        mfu_access(req, rsp);
        exp.wr   = 1'b0;
        exp.data = mfu_wdata;
        compare_mfu_rsp(rsp, exp, "MFU read back");
        req.addr = 22'h1F00D;
        mfu_access(req, rsp);
        exp.data = default_word(22'h1F00D);
        compare_mfu_rsp(rsp, exp, "MFU read of unwritten word");
    endtask

    task automatic replacement_and_clear();
        int low;
        // Five blocks for four buffers
        for (int k = 0; k < 5; k++) begin
            fetch_parcel({block_tag(k), 4'(k + 3), 2'(k)}, low);
            expect_flag(low > 1, 1'b1, "miss on a new block");
        end
        fetch_parcel({block_tag(0), 4'd9, 2'd3}, low);
        clear_ibuf = 1'b1;
        @(negedge clk);
        clear_ibuf = 1'b0;
        fetch_parcel({block_tag(0), 4'd9, 2'd3}, low);
        expect_flag(low > 1, 1'b1, "refill after clear");
    endtask

    task automatic mfu_during_fill();
        cray_mem_pkg::mfu_req_t req;
        cray_mem_pkg::mfu_rsp_t rsp;
        cray_mem_pkg::mfu_rsp_t exp;
        int                     low;
        req.wr   = 1'b0;
        req.addr = mfu_addr;
        req.data = '0;
        exp.wr   = 1'b0;
        exp.data = mfu_wdata;
        fork
            fetch_parcel({18'h0ABCD, 4'd7, 2'd1}, low);
            begin
                // Fill is well under way by now
                repeat (6) @(negedge clk);
                mfu_access(req, rsp);
            end
        join
        compare_mfu_rsp(rsp, exp, "MFU read during fill");
        check_block_hits(18'h0ABCD);
    endtask

    initial begin
        rst_n      = 1'b0;
        p_addr     = '0;
        clear_ibuf = 1'b0;
        mfu_valid  = 1'b0;
        mfu_req    = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        after_reset();
        miss_then_hits();
        mfu_write_then_read();
        replacement_and_clear();
        mfu_during_fill();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hw/cray_mem_pkg.sv
hw/mem_arb_fsm.sv
hw/ibuf_fill_counter.sv
hw/ibuf_store.sv
hw/mfu_port.sv
hw/cray_mem_front.sv
bench/tb_mem_model.sv
bench/tb_cray_mem_front.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory front end simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f flist.f \
    --top-module tb_cray_mem_front \
    -o tb_cray_mem_front

./obj_dir/tb_cray_mem_front
